// File: source/ompss_dbg_params.svh
`ifndef OMPSS_DBG_PARAMS_SVH
`define OMPSS_DBG_PARAMS_SVH

// accelerators behind the manager, at most 64.
`define OMPSS_MAX_ACCS      8
`define OMPSS_ACC_ID_W      3
`define OMPSS_AXI_ADDR_W    12

`define OMPSS_CMD_Q_DEPTH   8
`define OMPSS_FIN_Q_DEPTH   4
// wide enough for a full cmd queue on one accelerator.
`define OMPSS_PEND_W        4

`define OMPSS_REG_COPY_IN   'h0
`define OMPSS_REG_COPY_OUT  'h4
`define OMPSS_REG_AVAIL_LO  'h8
`define OMPSS_REG_AVAIL_HI  'hC
`define OMPSS_REG_NEMPTY_LO 'h10
`define OMPSS_REG_NEMPTY_HI 'h14

`define OMPSS_CMD_IN_BASE   'h800
`define OMPSS_CMD_OUT_BASE  'h900

`endif

// File: source/cmd_pkg.sv
`default_nettype none

`include "ompss_dbg_params.svh"

package cmd_pkg;

    // one queued command.
    typedef struct packed {
        logic [`OMPSS_ACC_ID_W-1:0] acc_id;
        logic [31:0]                data;
    } cmd_t;

    // completion as returned by an accelerator.
    typedef struct packed {
        logic [`OMPSS_ACC_ID_W-1:0] acc_id;
        logic [31:0]                result;
    } fin_t;

endpackage

`default_nettype wire

// File: source/dbg_pkg.sv
`default_nettype none

package dbg_pkg;

    // copy options reported as-is on the debug port.
    typedef struct packed {
        logic [31:0] copy_in_opt;
        logic [31:0] copy_out_opt;
    } dbg_regs_t;

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

endpackage

`default_nettype wire

// File: source/cmd_queue.sv
`default_nettype none
`timescale 1ns/10ps

module cmd_queue #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 8
) (
    input  wire      clk,
    input  wire      rstn,
    input  wire      push_valid,
    output logic     push_ready,
    input  wire      payload_t push_data,
    output logic     pop_valid,
    input  wire      pop_ready,
    output payload_t pop_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic push_ok;
    logic pop_ok;

    assign push_ready = count != CNT_W'(DEPTH);
    assign pop_valid = count != '0;
    assign pop_data = mem[rd_ptr];

    assign push_ok = push_valid && push_ready;
    assign pop_ok = pop_valid && pop_ready;

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (push_ok) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
        end
        if (pop_ok) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        end
        if (push_ok && !pop_ok) begin
            count <= count + 1'b1;
        end else if (pop_ok && !push_ok) begin
            count <= count - 1'b1;
        end

        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
    end

    // pointers only advance on their own handshake.
    a_wr_hold: assert property (@(posedge clk) disable iff (!rstn)
        !push_ok |=> $stable(wr_ptr));
    a_rd_hold: assert property (@(posedge clk) disable iff (!rstn)
        !pop_ok |=> $stable(rd_ptr));

endmodule

`default_nettype wire

// File: source/cmd_dispatcher.sv
`default_nettype none
`timescale 1ns/10ps

`include "ompss_dbg_params.svh"

module cmd_dispatcher (
    input  wire                         clk,
    input  wire                         rstn,
    input  wire                         in_seen_valid,
    input  wire [`OMPSS_ACC_ID_W-1:0]   in_seen_acc,
    input  wire                         head_valid,
    input  wire cmd_pkg::cmd_t          head_data,
    output logic                        head_pop,
    output logic                        acc_cmd_valid,
    input  wire                         acc_cmd_ready,
    output logic [`OMPSS_ACC_ID_W-1:0]  acc_cmd_acc_id,
    output logic [31:0]                 acc_cmd_data,
    input  wire                         acc_fin_valid,
    output logic                        acc_fin_ready,
    input  wire [`OMPSS_ACC_ID_W-1:0]   acc_fin_acc_id,
    input  wire [31:0]                  acc_fin_data,
    output logic                        fin_push_valid,
    input  wire                         fin_push_ready,
    output cmd_pkg::fin_t               fin_push_data,
    output logic [`OMPSS_MAX_ACCS-1:0]  acc_avail,
    output logic [`OMPSS_MAX_ACCS-1:0]  queue_nempty,
    output logic [31:0]                 cmd_in_n_cmds [`OMPSS_MAX_ACCS],
    output logic [31:0]                 cmd_out_n_cmds [`OMPSS_MAX_ACCS]
);

    localparam int N = `OMPSS_MAX_ACCS;

    logic [`OMPSS_PEND_W-1:0] pending [N];
    logic         head_avail;
    logic         dispatch;
    logic         fin_fire;
    logic [N-1:0] in_hit;
    logic [N-1:0] disp_hit;
    logic [N-1:0] fin_hit;

    // head of queue blocks everything behind it.
    assign head_avail = acc_avail[head_data.acc_id];
    assign acc_cmd_valid = head_valid && head_avail;
    assign acc_cmd_acc_id = head_data.acc_id;
    assign acc_cmd_data = head_data.data;
    assign head_pop = acc_cmd_ready && head_avail;
    assign dispatch = acc_cmd_valid && acc_cmd_ready;

    assign fin_push_valid = acc_fin_valid;
    assign acc_fin_ready = fin_push_ready;
    assign fin_push_data.acc_id = acc_fin_acc_id;
    assign fin_push_data.result = acc_fin_data;
    assign fin_fire = acc_fin_valid && fin_push_ready;

    assign in_hit = in_seen_valid ? N'(1) << in_seen_acc : '0;
    assign disp_hit = dispatch ? N'(1) << head_data.acc_id : '0;
    assign fin_hit = fin_fire ? N'(1) << acc_fin_acc_id : '0;

    always_comb begin
        for (int i = 0; i < N; i++) begin
            queue_nempty[i] = pending[i] != '0;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < N; i++) begin
            if (in_hit[i] && !disp_hit[i]) begin
                pending[i] <= pending[i] + 1'b1;
            end else if (disp_hit[i] && !in_hit[i]) begin
                pending[i] <= pending[i] - 1'b1;
            end
            if (disp_hit[i]) begin
                acc_avail[i] <= 1'b0; // busy until its completion is forwarded.
                cmd_in_n_cmds[i] <= cmd_in_n_cmds[i] + 32'd1;
            end else if (fin_hit[i]) begin
                acc_avail[i] <= 1'b1;
            end
            if (fin_hit[i]) begin
                cmd_out_n_cmds[i] <= cmd_out_n_cmds[i] + 32'd1;
            end
        end

        if (!rstn) begin
            acc_avail <= '1;
            for (int i = 0; i < N; i++) begin
                pending[i] <= '0;
                cmd_in_n_cmds[i] <= '0;
                cmd_out_n_cmds[i] <= '0;
            end
        end
    end

    // only an accelerator that was handed a command may complete.
    a_fin_busy: assert property (@(posedge clk) disable iff (!rstn)
        acc_fin_valid |-> !acc_avail[acc_fin_acc_id]);

endmodule

`default_nettype wire

// File: source/axilite_controller.sv
`default_nettype none
`timescale 1ns/10ps

`include "ompss_dbg_params.svh"

module axilite_controller (
    input  wire                          clk,
    input  wire                          rstn,
    input  wire                          axil_arvalid,
    output logic                         axil_arready,
    input  wire [`OMPSS_AXI_ADDR_W-1:0]  axil_araddr,
    input  wire [2:0]                    axil_arprot,
    output logic                         axil_rvalid,
    input  wire                          axil_rready,
    output logic [31:0]                  axil_rdata,
    output logic [1:0]                   axil_rresp,
    input  wire                          axil_awvalid,
    output logic                         axil_awready,
    input  wire [`OMPSS_AXI_ADDR_W-1:0]  axil_awaddr,
    input  wire [2:0]                    axil_awprot,
    input  wire                          axil_wvalid,
    output logic                         axil_wready,
    input  wire [31:0]                   axil_wdata,
    input  wire [3:0]                    axil_wstrb,
    output logic                         axil_bvalid,
    input  wire                          axil_bready,
    output logic [1:0]                   axil_bresp,
    input  wire dbg_pkg::dbg_regs_t      dbg_regs,
    input  wire [`OMPSS_MAX_ACCS-1:0]    acc_avail,
    input  wire [`OMPSS_MAX_ACCS-1:0]    queue_nempty,
    input  wire [31:0]                   cmd_in_n_cmds [`OMPSS_MAX_ACCS],
    input  wire [31:0]                   cmd_out_n_cmds [`OMPSS_MAX_ACCS]
);

    localparam int AW = `OMPSS_AXI_ADDR_W;
    localparam int ID_W = `OMPSS_ACC_ID_W;
    localparam logic [AW-1:0] IN_BASE = AW'(`OMPSS_CMD_IN_BASE);
    localparam logic [AW-1:0] IN_END = AW'(`OMPSS_CMD_IN_BASE + `OMPSS_MAX_ACCS * 4);
    localparam logic [AW-1:0] OUT_BASE = AW'(`OMPSS_CMD_OUT_BASE);
    localparam logic [AW-1:0] OUT_END = AW'(`OMPSS_CMD_OUT_BASE + `OMPSS_MAX_ACCS * 4);

    typedef enum logic [1:0] {
        R_AR,
        R_SELECT,
        R_DATA
    } rstate_t;

    typedef enum logic [1:0] {
        W_AW,
        W_W,
        W_B
    } wstate_t;

    rstate_t rstate;
    wstate_t wstate;

    logic [AW-1:0] raddr;
    logic [AW-1:0] in_off;
    logic [AW-1:0] out_off;
    logic [31:0]   rdata;
    logic [1:0]    rresp;
    logic [63:0]   avail_ext;
    logic [63:0]   nempty_ext;

    // bit vectors padded to two 32-bit words.
    assign avail_ext = 64'(acc_avail);
    assign nempty_ext = 64'(queue_nempty);
    assign in_off = raddr - IN_BASE;
    assign out_off = raddr - OUT_BASE;

    assign axil_arready = rstate == R_AR;
    assign axil_rvalid = rstate == R_DATA;
    assign axil_rdata = rdata;
    assign axil_rresp = rresp;
    assign axil_awready = wstate == W_AW;
    assign axil_wready = wstate == W_W;
    assign axil_bvalid = wstate == W_B;
    assign axil_bresp = dbg_pkg::resp_slverr; // no writable registers.

    always_ff @(posedge clk) begin
        case (rstate)
            R_AR: begin
                if (axil_arvalid) begin
                    raddr <= axil_araddr;
                    rstate <= R_SELECT;
                end
            end
            R_SELECT: begin
                rdata <= '0;
                rresp <= dbg_pkg::resp_okay;
                if (raddr < IN_BASE) begin
                    case (raddr)
                        `OMPSS_REG_COPY_IN:   rdata <= dbg_regs.copy_in_opt;
                        `OMPSS_REG_COPY_OUT:  rdata <= dbg_regs.copy_out_opt;
                        `OMPSS_REG_AVAIL_LO:  rdata <= avail_ext[31:0];
                        `OMPSS_REG_AVAIL_HI:  rdata <= avail_ext[63:32];
                        `OMPSS_REG_NEMPTY_LO: rdata <= nempty_ext[31:0];
                        `OMPSS_REG_NEMPTY_HI: rdata <= nempty_ext[63:32];
                        default:              rresp <= dbg_pkg::resp_slverr;
                    endcase
                end else if (raddr[1:0] != 2'd0) begin
                    rresp <= dbg_pkg::resp_slverr;
                end else if (raddr < IN_END) begin
                    rdata <= cmd_in_n_cmds[in_off[ID_W+1:2]];
                end else if (raddr >= OUT_BASE && raddr < OUT_END) begin
                    rdata <= cmd_out_n_cmds[out_off[ID_W+1:2]];
                end else begin
                    rresp <= dbg_pkg::resp_slverr; // gap between the arrays.
                end
                rstate <= R_DATA;
            end
            R_DATA: begin
                if (axil_rready) begin
                    rstate <= R_AR;
                end
            end
            default: rstate <= R_AR;
        endcase

        case (wstate)
            W_AW: begin
                if (axil_awvalid) begin
                    wstate <= W_W;
                end
            end
            W_W: begin
                if (axil_wvalid) begin
                    wstate <= W_B;
                end
            end
            W_B: begin
                if (axil_bready) begin
                    wstate <= W_AW;
                end
            end
            default: wstate <= W_AW;
        endcase

        if (!rstn) begin
            rstate <= R_AR;
            wstate <= W_AW;
        end
    end

    // read response held until the master takes it.
    a_r_stable: assert property (@(posedge clk) disable iff (!rstn)
        axil_rvalid && !axil_rready |=>
            axil_rvalid && $stable(axil_rdata) && $stable(axil_rresp));

endmodule

`default_nettype wire

// File: source/ompss_dbg_top.sv
`default_nettype none
`timescale 1ns/10ps

`include "ompss_dbg_params.svh"

module ompss_dbg_top (
    input  wire                          clk,
    input  wire                          rstn,
    input  wire                          cmd_in_valid,
    output logic                         cmd_in_ready,
    input  wire [`OMPSS_ACC_ID_W-1:0]    cmd_in_acc_id,
    input  wire [31:0]                   cmd_in_data,
    output logic                         acc_cmd_valid,
    input  wire                          acc_cmd_ready,
    output logic [`OMPSS_ACC_ID_W-1:0]   acc_cmd_acc_id,
    output logic [31:0]                  acc_cmd_data,
    input  wire                          acc_fin_valid,
    output logic                         acc_fin_ready,
    input  wire [`OMPSS_ACC_ID_W-1:0]    acc_fin_acc_id,
    input  wire [31:0]                   acc_fin_data,
    output logic                         fin_valid,
    input  wire                          fin_ready,
    output logic [`OMPSS_ACC_ID_W-1:0]   fin_acc_id,
    output logic [31:0]                  fin_data,
    input  wire                          axil_arvalid,
    output logic                         axil_arready,
    input  wire [`OMPSS_AXI_ADDR_W-1:0]  axil_araddr,
    input  wire [2:0]                    axil_arprot,
    output logic                         axil_rvalid,
    input  wire                          axil_rready,
    output logic [31:0]                  axil_rdata,
    output logic [1:0]                   axil_rresp,
    input  wire                          axil_awvalid,
    output logic                         axil_awready,
    input  wire [`OMPSS_AXI_ADDR_W-1:0]  axil_awaddr,
    input  wire [2:0]                    axil_awprot,
    input  wire                          axil_wvalid,
    output logic                         axil_wready,
    input  wire [31:0]                   axil_wdata,
    input  wire [3:0]                    axil_wstrb,
    output logic                         axil_bvalid,
    input  wire                          axil_bready,
    output logic [1:0]                   axil_bresp,
    input  wire dbg_pkg::dbg_regs_t      dbg_regs
);

    cmd_pkg::cmd_t cmd_in_pkt;
    cmd_pkg::cmd_t cmd_head;
    cmd_pkg::fin_t fin_push_data;
    cmd_pkg::fin_t fin_pop_data;

    logic in_seen_valid;
    logic cmd_head_valid;
    logic cmd_head_pop;
    logic fin_push_valid;
    logic fin_push_ready;
    logic [`OMPSS_MAX_ACCS-1:0] acc_avail;
    logic [`OMPSS_MAX_ACCS-1:0] queue_nempty;
    logic [31:0] cmd_in_n_cmds [`OMPSS_MAX_ACCS];
    logic [31:0] cmd_out_n_cmds [`OMPSS_MAX_ACCS];

    assign cmd_in_pkt.acc_id = cmd_in_acc_id;
    assign cmd_in_pkt.data = cmd_in_data;
    assign in_seen_valid = cmd_in_valid && cmd_in_ready; // accepted into the queue.
    assign fin_acc_id = fin_pop_data.acc_id;
    assign fin_data = fin_pop_data.result;

    cmd_queue #(
        .payload_t (cmd_pkg::cmd_t),
        .DEPTH     (`OMPSS_CMD_Q_DEPTH)
    ) i_cmd_queue (
        .clk        (clk),
        .rstn       (rstn),
        .push_valid (cmd_in_valid),
        .push_ready (cmd_in_ready),
        .push_data  (cmd_in_pkt),
        .pop_valid  (cmd_head_valid),
        .pop_ready  (cmd_head_pop),
        .pop_data   (cmd_head)
    );

    cmd_dispatcher i_cmd_dispatcher (
        .clk            (clk),
        .rstn           (rstn),
        .in_seen_valid  (in_seen_valid),
        .in_seen_acc    (cmd_in_acc_id),
        .head_valid     (cmd_head_valid),
        .head_data      (cmd_head),
        .head_pop       (cmd_head_pop),
        .acc_cmd_valid  (acc_cmd_valid),
        .acc_cmd_ready  (acc_cmd_ready),
        .acc_cmd_acc_id (acc_cmd_acc_id),
        .acc_cmd_data   (acc_cmd_data),
        .acc_fin_valid  (acc_fin_valid),
        .acc_fin_ready  (acc_fin_ready),
        .acc_fin_acc_id (acc_fin_acc_id),
        .acc_fin_data   (acc_fin_data),
        .fin_push_valid (fin_push_valid),
        .fin_push_ready (fin_push_ready),
        .fin_push_data  (fin_push_data),
        .acc_avail      (acc_avail),
        .queue_nempty   (queue_nempty),
        .cmd_in_n_cmds  (cmd_in_n_cmds),
        .cmd_out_n_cmds (cmd_out_n_cmds)
    );

    cmd_queue #(
        .payload_t (cmd_pkg::fin_t),
        .DEPTH     (`OMPSS_FIN_Q_DEPTH)
    ) i_fin_queue (
        .clk        (clk),
        .rstn       (rstn),
        .push_valid (fin_push_valid),
        .push_ready (fin_push_ready),
        .push_data  (fin_push_data),
        .pop_valid  (fin_valid),
        .pop_ready  (fin_ready),
        .pop_data   (fin_pop_data)
    );

    axilite_controller i_axilite_controller (
        .clk            (clk),
        .rstn           (rstn),
        .axil_arvalid   (axil_arvalid),
        .axil_arready   (axil_arready),
        .axil_araddr    (axil_araddr),
        .axil_arprot    (axil_arprot),
        .axil_rvalid    (axil_rvalid),
        .axil_rready    (axil_rready),
        .axil_rdata     (axil_rdata),
        .axil_rresp     (axil_rresp),
        .axil_awvalid   (axil_awvalid),
        .axil_awready   (axil_awready),
        .axil_awaddr    (axil_awaddr),
        .axil_awprot    (axil_awprot),
        .axil_wvalid    (axil_wvalid),
        .axil_wready    (axil_wready),
        .axil_wdata     (axil_wdata),
        .axil_wstrb     (axil_wstrb),
        .axil_bvalid    (axil_bvalid),
        .axil_bready    (axil_bready),
        .axil_bresp     (axil_bresp),
        .dbg_regs       (dbg_regs),
        .acc_avail      (acc_avail),
        .queue_nempty   (queue_nempty),
        .cmd_in_n_cmds  (cmd_in_n_cmds),
        .cmd_out_n_cmds (cmd_out_n_cmds)
    );

endmodule

`default_nettype wire

// File: bench/tb_ompss_dbg.sv
`default_nettype none
`timescale 1ns/10ps

`include "ompss_dbg_params.svh"

module tb_ompss_dbg;

    localparam int N = `OMPSS_MAX_ACCS;
    localparam int AW = `OMPSS_AXI_ADDR_W;
    localparam int ID_W = `OMPSS_ACC_ID_W;
    localparam int N_RANDOM = 60;
    localparam int N_HELD = 4;
    localparam int HELD_ACC = 2;
    localparam int TIMEOUT_NS = ((N_RANDOM + N_HELD) * 200 + 2000) * 10; // 200 cycles a command.
    localparam logic [31:0] AVAIL_ALL = 32'((64'd1 << N) - 1);

    logic clk;
    logic rstn;
    logic cmd_in_valid;
    logic cmd_in_ready;
    logic [ID_W-1:0] cmd_in_acc_id;
    logic [31:0] cmd_in_data;
    logic acc_cmd_valid;
    logic acc_cmd_ready;
    logic [ID_W-1:0] acc_cmd_acc_id;
    logic [31:0] acc_cmd_data;
    logic acc_fin_valid;
    logic acc_fin_ready;
    logic [ID_W-1:0] acc_fin_acc_id;
    logic [31:0] acc_fin_data;
    logic fin_valid;
    logic fin_ready;
    logic [ID_W-1:0] fin_acc_id;
    logic [31:0] fin_data;
    logic axil_arvalid;
    logic axil_arready;
    logic [AW-1:0] axil_araddr;
    logic axil_rvalid;
    logic axil_rready;
    logic [31:0] axil_rdata;
    logic [1:0] axil_rresp;
    logic axil_awvalid;
    logic axil_awready;
    logic [AW-1:0] axil_awaddr;
    logic axil_wvalid;
    logic axil_wready;
    logic [31:0] axil_wdata;
    logic [3:0] axil_wstrb;
    logic axil_bvalid;
    logic axil_bready;
    logic [1:0] axil_bresp;
    dbg_pkg::dbg_regs_t dbg_regs;

    int errors;
    int fins_checked;
    int issued [N];
    int acc_wait [N];
    int fin_sel;
    logic hold;
    logic [N-1:0] busy;
    logic [31:0] acc_res [N];
    cmd_pkg::cmd_t exp_cmds [$];
    cmd_pkg::fin_t exp_fins [$];
    cmd_pkg::cmd_t cmd_got;
    cmd_pkg::fin_t fin_got;
    cmd_pkg::fin_t fin_new;

    ompss_dbg_top i_ompss_dbg_top (
        .clk (clk), .rstn (rstn),
        .cmd_in_valid (cmd_in_valid), .cmd_in_ready (cmd_in_ready),
        .cmd_in_acc_id (cmd_in_acc_id), .cmd_in_data (cmd_in_data),
        .acc_cmd_valid (acc_cmd_valid), .acc_cmd_ready (acc_cmd_ready),
        .acc_cmd_acc_id (acc_cmd_acc_id), .acc_cmd_data (acc_cmd_data),
        .acc_fin_valid (acc_fin_valid), .acc_fin_ready (acc_fin_ready),
        .acc_fin_acc_id (acc_fin_acc_id), .acc_fin_data (acc_fin_data),
        .fin_valid (fin_valid), .fin_ready (fin_ready),
        .fin_acc_id (fin_acc_id), .fin_data (fin_data),
        .axil_arvalid (axil_arvalid), .axil_arready (axil_arready),
        .axil_araddr (axil_araddr), .axil_arprot (3'd0),
        .axil_rvalid (axil_rvalid), .axil_rready (axil_rready),
        .axil_rdata (axil_rdata), .axil_rresp (axil_rresp),
        .axil_awvalid (axil_awvalid), .axil_awready (axil_awready),
        .axil_awaddr (axil_awaddr), .axil_awprot (3'd0),
        .axil_wvalid (axil_wvalid), .axil_wready (axil_wready),
        .axil_wdata (axil_wdata), .axil_wstrb (axil_wstrb),
        .axil_bvalid (axil_bvalid), .axil_bready (axil_bready),
        .axil_bresp (axil_bresp), .dbg_regs (dbg_regs)
    );

    always #5 clk = ~clk;

    task automatic flag_error(input string msg);
        errors++;
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    task automatic skip_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic axil_read(input logic [AW-1:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        axil_arvalid = 1'b1;
        axil_araddr = addr;
        do @(posedge clk); while (!axil_arready);
        #1 axil_arvalid = 1'b0;
        skip_cycles($urandom_range(0, 2)); // lets rvalid wait on rready.
        axil_rready = 1'b1;
        do @(posedge clk); while (!axil_rvalid);
        data = axil_rdata;
        resp = axil_rresp;
        #1 axil_rready = 1'b0;
    endtask

    task automatic expect_read(input logic [AW-1:0] addr, input logic [31:0] exp_data,
                               input logic [1:0] exp_resp);
        logic [31:0] data;
        logic [1:0] resp;
        axil_read(addr, data, resp);
        assert (resp == exp_resp && (resp != dbg_pkg::resp_okay || data == exp_data))
            else flag_error($sformatf("read 0x%03h gave 0x%08h resp %0d, expected 0x%08h resp %0d",
                                      addr, data, resp, exp_data, exp_resp));
    endtask

    task automatic expect_write_error(input logic [AW-1:0] addr);
        axil_awvalid = 1'b1;
        axil_awaddr = addr;
        do @(posedge clk); while (!axil_awready);
        #1 axil_awvalid = 1'b0;
        axil_wvalid = 1'b1;
        axil_wdata = $urandom;
        do @(posedge clk); while (!axil_wready);
        #1 axil_wvalid = 1'b0;
        axil_bready = 1'b1;
        do @(posedge clk); while (!axil_bvalid);
        assert (axil_bresp == dbg_pkg::resp_slverr)
            else flag_error($sformatf("write 0x%03h answered %0d", addr, axil_bresp));
        #1 axil_bready = 1'b0;
    endtask

    task automatic send_cmd(input logic [ID_W-1:0] acc, input logic [31:0] data);
        cmd_pkg::cmd_t c;
        c.acc_id = acc;
        c.data = data;
        cmd_in_valid = 1'b1;
        cmd_in_acc_id = acc;
        cmd_in_data = data;
        do @(posedge clk); while (!cmd_in_ready);
        exp_cmds.push_back(c);
        issued[acc]++;
        #1 cmd_in_valid = 1'b0;
    endtask

    task automatic wait_drained();
        @(posedge clk);
        while (exp_cmds.size() != 0 || busy != '0 || exp_fins.size() != 0) @(posedge clk);
        #1;
        skip_cycles(2);
    endtask

    task automatic check_counters();
        for (int i = 0; i < N; i++) begin
            expect_read(AW'(`OMPSS_CMD_IN_BASE + 4 * i), 32'(issued[i]), dbg_pkg::resp_okay);
            expect_read(AW'(`OMPSS_CMD_OUT_BASE + 4 * i), 32'(issued[i]), dbg_pkg::resp_okay);
        end
    endtask

    // accelerator side, one outstanding command each.
    always @(posedge clk) begin
        if (rstn) begin
            if (acc_cmd_valid && acc_cmd_ready) begin
                assert (exp_cmds.size() != 0) else flag_error("command dispatched but none queued");
                if (exp_cmds.size() != 0) begin
                    cmd_got = exp_cmds.pop_front();
                    assert (acc_cmd_acc_id == cmd_got.acc_id && acc_cmd_data == cmd_got.data)
                        else flag_error($sformatf("acc_cmd %0d/0x%08h, expected %0d/0x%08h",
                            acc_cmd_acc_id, acc_cmd_data, cmd_got.acc_id, cmd_got.data));
                end
                assert (!busy[acc_cmd_acc_id])
                    else flag_error($sformatf("accelerator %0d got a second command", acc_cmd_acc_id));
                busy[acc_cmd_acc_id] = 1'b1;
                acc_res[acc_cmd_acc_id] = acc_cmd_data + 32'd1;
                acc_wait[acc_cmd_acc_id] = $urandom_range(1, 12);
            end
            if (acc_fin_valid && acc_fin_ready) begin
                busy[fin_sel] = 1'b0;
                fin_new.acc_id = ID_W'(fin_sel);
                fin_new.result = acc_res[fin_sel];
                exp_fins.push_back(fin_new);
                fin_sel = -1;
            end
            for (int i = 0; i < N; i++) begin
                if (acc_wait[i] > 0) begin
                    acc_wait[i]--;
                end
            end
            for (int i = N - 1; i >= 0 && fin_sel < 0; i--) begin
                if (busy[i] && acc_wait[i] == 0 && !(hold && i == HELD_ACC)) begin
                    fin_sel = i;
                end
            end
        end
        #1;
        acc_cmd_ready = $urandom_range(0, 1);
        acc_fin_valid = fin_sel >= 0;
        if (fin_sel >= 0) begin
            acc_fin_acc_id = ID_W'(fin_sel);
            acc_fin_data = acc_res[fin_sel];
        end
    end

    // result stream sink.
    always @(posedge clk) begin
        if (rstn && fin_valid && fin_ready) begin
            assert (exp_fins.size() != 0) else flag_error("result appeared with none completed");
            if (exp_fins.size() != 0) begin
                fin_got = exp_fins.pop_front();
                fins_checked++;
                assert (fin_acc_id == fin_got.acc_id && fin_data == fin_got.result)
                    else flag_error($sformatf("fin %0d/0x%08h, expected %0d/0x%08h",
                        fin_acc_id, fin_data, fin_got.acc_id, fin_got.result));
            end
        end
        #1;
        fin_ready = $urandom_range(0, 3) != 0;
    end

    a_reset_idle: assert property (@(posedge clk) !rstn |=>
        axil_arready && axil_awready && !axil_rvalid && !axil_bvalid && !acc_cmd_valid
        && !fin_valid)
        else flag_error("interface not idle after reset");
    a_cmd_hold: assert property (@(posedge clk) disable iff (!rstn)
        acc_cmd_valid && !acc_cmd_ready |=>
            acc_cmd_valid && $stable(acc_cmd_data) && $stable(acc_cmd_acc_id))
        else flag_error("acc_cmd dropped or changed before its handshake");
    a_fin_hold: assert property (@(posedge clk) disable iff (!rstn)
        fin_valid && !fin_ready |=> fin_valid && $stable(fin_data) && $stable(fin_acc_id))
        else flag_error("fin dropped or changed before its handshake");

    initial begin
        void'($urandom(11558));
        clk = 1'b0;
        rstn = 1'b0;
        {cmd_in_valid, acc_cmd_ready, acc_fin_valid, fin_ready} = '0;
        {cmd_in_acc_id, cmd_in_data, acc_fin_acc_id, acc_fin_data} = '0;
        {axil_arvalid, axil_araddr, axil_rready, axil_awvalid, axil_awaddr} = '0;
        {axil_wvalid, axil_wdata, axil_bready} = '0;
        axil_wstrb = 4'hF;
        dbg_regs.copy_in_opt = $urandom;
        dbg_regs.copy_out_opt = $urandom;
        {errors, fins_checked, hold, busy} = '0;
        fin_sel = -1;
        for (int i = 0; i < N; i++) begin
            issued[i] = 0;
            acc_wait[i] = 0;
            acc_res[i] = '0;
        end
        repeat (16) @(posedge clk);
        #1 rstn = 1'b1;
        skip_cycles(1);

        expect_read(AW'(`OMPSS_REG_AVAIL_LO), AVAIL_ALL, dbg_pkg::resp_okay);
        check_counters();

        for (int k = 0; k < N_RANDOM; k++) begin
            send_cmd(ID_W'($urandom_range(0, N - 1)), $urandom);
            skip_cycles($urandom_range(0, 2));
        end
        wait_drained();
        check_counters();

        // one accelerator kept busy so its commands pile up.
        hold = 1'b1;
        for (int k = 0; k < N_HELD; k++) begin
            send_cmd(ID_W'(HELD_ACC), $urandom);
        end
        while (!busy[HELD_ACC]) skip_cycles(1);
        skip_cycles(2);
        expect_read(AW'(`OMPSS_REG_NEMPTY_LO), 32'd1 << HELD_ACC, dbg_pkg::resp_okay);
        expect_read(AW'(`OMPSS_REG_AVAIL_LO), AVAIL_ALL & ~(32'd1 << HELD_ACC),
                    dbg_pkg::resp_okay);
        hold = 1'b0;
        wait_drained();
        check_counters();

        expect_read(AW'(`OMPSS_REG_COPY_IN), dbg_regs.copy_in_opt, dbg_pkg::resp_okay);
        expect_read(AW'(`OMPSS_REG_COPY_OUT), dbg_regs.copy_out_opt, dbg_pkg::resp_okay);
        expect_read(AW'('h2), '0, dbg_pkg::resp_slverr);
        expect_read(AW'('h18), '0, dbg_pkg::resp_slverr);
        expect_read(AW'(`OMPSS_CMD_IN_BASE + 4 * N), '0, dbg_pkg::resp_slverr);
        expect_write_error(AW'(`OMPSS_REG_COPY_IN));
        expect_write_error(AW'(`OMPSS_REG_AVAIL_LO));
        expect_write_error(AW'(`OMPSS_CMD_IN_BASE));

        $display("errors: %0d, commands: %0d, results checked: %0d",
                 errors, N_RANDOM + N_HELD, fins_checked);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+source
source/cmd_pkg.sv
source/dbg_pkg.sv
source/cmd_queue.sv
source/cmd_dispatcher.sv
source/axilite_controller.sv
source/ompss_dbg_top.sv
bench/tb_ompss_dbg.sv

// File: Bender.yml
package:
  name: ompss_dbg

export_include_dirs:
  - source

sources:
  - files:
      - source/cmd_pkg.sv
      - source/dbg_pkg.sv
      - source/cmd_queue.sv
      - source/cmd_dispatcher.sv
      - source/axilite_controller.sv
      - source/ompss_dbg_top.sv
  - target: test
    files:
      - bench/tb_ompss_dbg.sv
